//--- logic/fifo_defines.svh
`ifndef FIFO_DEFINES_SVH
`define FIFO_DEFINES_SVH

// ---------------------------------------------------------------------------
// geometry
// ---------------------------------------------------------------------------
`define FIFO_DATA_W     32    // payload word
`define FIFO_ADDR_W     4     // ram address bits
`define FIFO_DEPTH      16    // entries, 2**FIFO_ADDR_W
`define FIFO_CODE_W     39    // 32 data + 6 hamming + 1 overall parity

// ---------------------------------------------------------------------------
// timing and thresholds
// ---------------------------------------------------------------------------
`define FIFO_RD_STAGES  2     // read latency in cycles
`define FIFO_PE_ASSERT  4     // prog_empty sets at or below
`define FIFO_PE_NEGATE  6     // prog_empty clears above

`endif

//--- logic/fifo_pkg.sv
`default_nettype none

`include "fifo_defines.svh"

package fifo_pkg;

    // -----------------------------------------------------------------------
    // datapath types
    // -----------------------------------------------------------------------
    typedef logic [`FIFO_DATA_W-1:0] data_t;     // one payload word
    typedef logic [`FIFO_CODE_W-1:0] code_t;     // stored secded word
    typedef logic [`FIFO_ADDR_W-1:0] addr_t;     // ram index
    typedef logic [`FIFO_ADDR_W:0]   count_t;    // 0..depth, one extra bit

    // -----------------------------------------------------------------------
    // opcodes and states
    // -----------------------------------------------------------------------
    // error injection applied to the written codeword
    typedef enum logic [1:0] {
        INJ_NONE   = 2'd0,    // store clean code
        INJ_SINGLE = 2'd1,    // flip code bit 3
        INJ_DOUBLE = 2'd2     // flip code bits 3 and 17
    } inj_mode_e;

    // occupancy class, drives empty and full directly
    typedef enum logic [1:0] {
        FILL_EMPTY   = 2'd0,  // nothing stored
        FILL_PARTIAL = 2'd1,  // somewhere in between
        FILL_FULL    = 2'd2   // all entries used
    } fill_state_e;

endpackage

`default_nettype wire

//--- logic/fifo_ram_if.sv
`default_nettype none

// write and read port of the fifo storage, no handshake
interface fifo_ram_if;

    logic            wen;      // store wdata at waddr this edge
    fifo_pkg::addr_t waddr;    // write slot
    fifo_pkg::data_t wdata;    // raw payload, encoded inside the ram
    logic            ren;      // launch read of raddr this edge
    fifo_pkg::addr_t raddr;    // read slot

    // controller side owns every signal
    modport ctrl (
        output wen,
        output waddr,
        output wdata,
        output ren,
        output raddr
    );

    // storage side only listens
    modport ram (
        input  wen,
        input  waddr,
        input  wdata,
        input  ren,
        input  raddr
    );

endinterface

`default_nettype wire

//--- logic/fifo_ctrl.sv
`default_nettype none

`include "fifo_defines.svh"

module fifo_ctrl (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr_en,                 // producer write request
    input  fifo_pkg::data_t  wr_data,               // payload routed to the ram
    input  logic             rd_en,                 // consumer read request
    input  fifo_pkg::count_t prog_full_assert_cfg,  // prog_full set level
    input  fifo_pkg::count_t prog_full_negate_cfg,  // prog_full clear level
    fifo_ram_if.ctrl         ram,
    output logic             empty,
    output logic             full,
    output logic             prog_empty,
    output logic             prog_full,
    output logic             ovf_int,               // one cycle pulse on write while full
    output logic             udf_int                // one cycle pulse on read while empty
);

    localparam fifo_pkg::count_t DEPTH     = fifo_pkg::count_t'(`FIFO_DEPTH);
    localparam fifo_pkg::addr_t  LAST_ADDR = fifo_pkg::addr_t'(`FIFO_DEPTH - 1);
    localparam fifo_pkg::count_t PE_ASSERT = fifo_pkg::count_t'(`FIFO_PE_ASSERT);
    localparam fifo_pkg::count_t PE_NEGATE = fifo_pkg::count_t'(`FIFO_PE_NEGATE);

    fifo_pkg::addr_t       wr_ptr;          // next slot to write
    fifo_pkg::addr_t       rd_ptr;          // next slot to read
    fifo_pkg::count_t      count;           // current occupancy
    fifo_pkg::count_t      count_nxt;       // occupancy after this edge
    fifo_pkg::fill_state_e state;
    fifo_pkg::fill_state_e state_nxt;
    logic                  wen;             // accepted write
    logic                  ren;             // accepted read
    logic                  prog_full_nxt;
    logic                  prog_empty_nxt;

    // ---------------------------------------------------------------------------
    // guarded enables and ram port
    // ---------------------------------------------------------------------------
    assign wen = wr_en && !full;            // drop writes when full
    assign ren = rd_en && !empty;           // ignore reads when empty

    assign ram.wen   = wen;
    assign ram.waddr = wr_ptr;
    assign ram.wdata = wr_data;
    assign ram.ren   = ren;
    assign ram.raddr = rd_ptr;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (wen)
                wr_ptr <= (wr_ptr == LAST_ADDR) ? '0 : wr_ptr + 1'b1;  // wrap at depth
            if (ren)
                rd_ptr <= (rd_ptr == LAST_ADDR) ? '0 : rd_ptr + 1'b1;
        end
    end

    // ---------------------------------------------------------------------------
    // next occupancy and flags all derived from count_nxt
    // ---------------------------------------------------------------------------
    always_comb
    begin
        case ({wen, ren})
            2'b10:   count_nxt = count + 1'b1;
            2'b01:   count_nxt = count - 1'b1;
            default: count_nxt = count;     // idle or simultaneous
        endcase
    end

    always_comb
    begin
        if (count_nxt == '0)
            state_nxt = fifo_pkg::FILL_EMPTY;
        else if (count_nxt == DEPTH)
            state_nxt = fifo_pkg::FILL_FULL;
        else
            state_nxt = fifo_pkg::FILL_PARTIAL;
    end

    always_comb
    begin
        prog_full_nxt  = prog_full;         // hold inside the band
        prog_empty_nxt = prog_empty;
        if (!prog_full && (count_nxt >= prog_full_assert_cfg))
            prog_full_nxt = 1'b1;
        else if (prog_full && (count_nxt < prog_full_negate_cfg))
            prog_full_nxt = 1'b0;
        if (!prog_empty && (count_nxt <= PE_ASSERT))
            prog_empty_nxt = 1'b1;
        else if (prog_empty && (count_nxt > PE_NEGATE))
            prog_empty_nxt = 1'b0;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count      <= '0;
            state      <= fifo_pkg::FILL_EMPTY;
            prog_full  <= 1'b0;
            prog_empty <= 1'b1;
            ovf_int    <= 1'b0;
            udf_int    <= 1'b0;
        end
        else
        begin
            count      <= count_nxt;
            state      <= state_nxt;
            prog_full  <= prog_full_nxt;
            prog_empty <= prog_empty_nxt;
            ovf_int    <= wr_en && full;    // rejected write
            udf_int    <= rd_en && empty;   // rejected read
        end
    end

    assign empty = (state == fifo_pkg::FILL_EMPTY);
    assign full  = (state == fifo_pkg::FILL_FULL);

    // ---------------------------------------------------------------------------
    // checks
    // ---------------------------------------------------------------------------
    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count <= DEPTH);
    a_ram_guard: assert property (@(posedge clk) disable iff (!rst_n)
        !(ram.wen && full) && !(ram.ren && empty));

endmodule

`default_nettype wire

//--- logic/ecc_ram.sv
`default_nettype none

`include "fifo_defines.svh"

module ecc_ram (
    input  logic                clk,
    input  logic                rst_n,
    input  fifo_pkg::inj_mode_e inj_mode,     // corrupt the word being written
    fifo_ram_if.ram             ram,
    output fifo_pkg::data_t     rd_data,
    output logic                rd_valid,
    output logic                single_err,   // corrected flip on this word
    output logic                double_err    // uncorrectable so data untrusted
);

    localparam int CODE_W    = `FIFO_CODE_W;
    localparam int HAM_W     = `FIFO_CODE_W - `FIFO_DATA_W - 1;  // check bits
    localparam int STAGES    = `FIFO_RD_STAGES;
    localparam int INJ_BIT_A = 3;
    localparam int INJ_BIT_B = 17;

    // ---------------------------------------------------------------------------
    // secded helpers with overall parity in bit 0 and hamming positions 1..38
    // ---------------------------------------------------------------------------
    function automatic fifo_pkg::code_t ecc_encode(input fifo_pkg::data_t d);
        fifo_pkg::code_t c;
        int              j;
        c = '0;
        j = 0;
        for (int p = 1; p < CODE_W; p++)
        begin
            if ((p & (p - 1)) != 0)         // data on non power of two slots
            begin
                c[p] = d[j];
                j++;
            end
        end
        for (int k = 0; k < HAM_W; k++)
        begin
            for (int p = 1; p < CODE_W; p++)
            begin
                if ((((p >> k) & 1) != 0) && (p != (1 << k)))
                    c[1 << k] = c[1 << k] ^ c[p];
            end
        end
        c[0] = ^c[CODE_W-1:1];              // even parity over whole word
        return c;
    endfunction

    function automatic logic [HAM_W-1:0] ecc_syndrome(input fifo_pkg::code_t c);
        logic [HAM_W-1:0] s;
        s = '0;
        for (int k = 0; k < HAM_W; k++)
        begin
            for (int p = 1; p < CODE_W; p++)
            begin
                if (((p >> k) & 1) != 0)
                    s[k] = s[k] ^ c[p];
            end
        end
        return s;                           // position of a single flip
    endfunction

    function automatic fifo_pkg::data_t ecc_extract(input fifo_pkg::code_t c);
        fifo_pkg::data_t d;
        int              j;
        d = '0;
        j = 0;
        for (int p = 1; p < CODE_W; p++)
        begin
            if ((p & (p - 1)) != 0)
            begin
                d[j] = c[p];
                j++;
            end
        end
        return d;
    endfunction

    fifo_pkg::code_t   mem [`FIFO_DEPTH];   // storage array
    fifo_pkg::code_t   inj_mask;
    fifo_pkg::code_t   wr_code;             // encoded and possibly corrupted
    fifo_pkg::code_t   s1_code;             // stage 1 raw codeword
    fifo_pkg::code_t   fixed_code;          // stage 2 after correction
    logic [STAGES-1:0] vld_pipe;
    logic [HAM_W-1:0]  syndrome;
    logic              parity_odd;
    logic              is_single;
    logic              is_double;

    // ---------------------------------------------------------------------------
    // write side
    // ---------------------------------------------------------------------------
    always_comb
    begin
        inj_mask = '0;
        case (inj_mode)
            fifo_pkg::INJ_SINGLE: inj_mask[INJ_BIT_A] = 1'b1;
            fifo_pkg::INJ_DOUBLE:
            begin
                inj_mask[INJ_BIT_A] = 1'b1;
                inj_mask[INJ_BIT_B] = 1'b1;
            end
            default: inj_mask = '0;
        endcase
    end

    assign wr_code = ecc_encode(ram.wdata) ^ inj_mask;

    always_ff @(posedge clk)
    begin
        if (ram.wen)
            mem[ram.waddr] <= wr_code;
        if (ram.ren)
            s1_code <= mem[ram.raddr];      // stage 1
    end

    // ---------------------------------------------------------------------------
    // read side decode, stage 2
    // ---------------------------------------------------------------------------
    always_comb
    begin
        syndrome   = ecc_syndrome(s1_code);
        parity_odd = ^s1_code;
        fixed_code = s1_code;
        // odd parity with syndrome 0 means the parity bit itself flipped
        is_single  = parity_odd && (int'(syndrome) < CODE_W);
        is_double  = (!parity_odd && (syndrome != '0)) || (parity_odd && !is_single);
        if (is_single && (syndrome != '0))
            fixed_code[syndrome] = ~s1_code[syndrome];
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            vld_pipe   <= '0;
            single_err <= 1'b0;
            double_err <= 1'b0;
        end
        else
        begin
            vld_pipe   <= {vld_pipe[STAGES-2:0], ram.ren};
            single_err <= vld_pipe[0] && is_single;
            double_err <= vld_pipe[0] && is_double;
        end
    end

    always_ff @(posedge clk)
    begin
        if (vld_pipe[0])
            rd_data <= ecc_extract(fixed_code);
    end

    assign rd_valid = vld_pipe[STAGES-1];

    // ---------------------------------------------------------------------------
    // checks
    // ---------------------------------------------------------------------------
    a_err_class: assert property (@(posedge clk) disable iff (!rst_n)
        (single_err || double_err) |-> (rd_valid && !(single_err && double_err)));

endmodule

`default_nettype wire

//--- logic/sync_fifo_top.sv
`default_nettype none

module sync_fifo_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_en,
    input  fifo_pkg::data_t     wr_data,
    input  logic                rd_en,
    input  fifo_pkg::inj_mode_e inj_mode,
    input  fifo_pkg::count_t    prog_full_assert_cfg,
    input  fifo_pkg::count_t    prog_full_negate_cfg,
    output fifo_pkg::data_t     rd_data,
    output logic                rd_valid,
    output logic                empty,
    output logic                full,
    output logic                prog_empty,
    output logic                prog_full,
    output logic                ovf_int,
    output logic                udf_int,
    output logic                single_err,
    output logic                double_err
);

    fifo_ram_if u_ram_if ();                // ctrl to storage port

    // pointers, count and flags
    fifo_ctrl u_ctrl (
        .clk                  (clk),
        .rst_n                (rst_n),
        .wr_en                (wr_en),
        .wr_data              (wr_data),
        .rd_en                (rd_en),
        .prog_full_assert_cfg (prog_full_assert_cfg),
        .prog_full_negate_cfg (prog_full_negate_cfg),
        .ram                  (u_ram_if),
        .empty                (empty),
        .full                 (full),
        .prog_empty           (prog_empty),
        .prog_full            (prog_full),
        .ovf_int              (ovf_int),
        .udf_int              (udf_int)
    );

    // secded storage with two stage read
    ecc_ram u_ram (
        .clk        (clk),
        .rst_n      (rst_n),
        .inj_mode   (inj_mode),
        .ram        (u_ram_if),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid),
        .single_err (single_err),
        .double_err (double_err)
    );

endmodule

`default_nettype wire

//--- dv/tb_sync_fifo.sv
`default_nettype none

`include "fifo_defines.svh"

module tb_sync_fifo;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CYCLE_LIMIT = 3000;          // about twice the stimulus length
    localparam int PF_ASSERT   = 12;
    localparam int PF_NEGATE   = 9;

    typedef struct packed {
        logic empty;
        logic full;
        logic prog_empty;
        logic prog_full;
        logic ovf_int;
        logic udf_int;
    } flags_t;

    logic                clk;
    logic                rst_n;
    logic                wr_en;
    logic                rd_en;
    fifo_pkg::data_t     wr_data;
    fifo_pkg::inj_mode_e inj_mode;
    fifo_pkg::count_t    prog_full_assert_cfg;
    fifo_pkg::count_t    prog_full_negate_cfg;
    fifo_pkg::data_t     rd_data;
    logic                rd_valid;
    logic                empty;
    logic                full;
    logic                prog_empty;
    logic                prog_full;
    logic                ovf_int;
    logic                udf_int;
    logic                single_err;
    logic                double_err;

    int                  cyc;                   // rising edges seen so far
    logic [31:0]         rng;
    int                  model_count;           // reference occupancy
    logic                model_pf;
    logic                model_pe;
    fifo_pkg::data_t     wq_data [$];           // words held in the fifo
    fifo_pkg::inj_mode_e wq_inj [$];
    fifo_pkg::data_t     exp_data [$];          // reads in flight
    fifo_pkg::inj_mode_e exp_inj [$];
    int                  exp_due [$];           // edge where rd_valid is due

    sync_fifo_top u_dut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .wr_en                (wr_en),
        .wr_data              (wr_data),
        .rd_en                (rd_en),
        .inj_mode             (inj_mode),
        .prog_full_assert_cfg (prog_full_assert_cfg),
        .prog_full_negate_cfg (prog_full_negate_cfg),
        .rd_data              (rd_data),
        .rd_valid             (rd_valid),
        .empty                (empty),
        .full                 (full),
        .prog_empty           (prog_empty),
        .prog_full            (prog_full),
        .ovf_int              (ovf_int),
        .udf_int              (udf_int),
        .single_err           (single_err),
        .double_err           (double_err)
    );

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // flag set after an edge with hysteresis keyed on the previous prog flags
    function automatic flags_t expected_flags(input int cnt, input logic pf_prev,
                                              input logic pe_prev, input logic ovf,
                                              input logic udf);
        flags_t f;
        f.empty      = (cnt == 0);
        f.full       = (cnt == `FIFO_DEPTH);
        f.prog_full  = pf_prev ? (cnt >= PF_NEGATE) : (cnt >= PF_ASSERT);
        f.prog_empty = pe_prev ? (cnt <= `FIFO_PE_NEGATE) : (cnt <= `FIFO_PE_ASSERT);
        f.ovf_int    = ovf;                     // write while full
        f.udf_int    = udf;                     // read while empty
        return f;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_mismatch(input string msg);
        abort_run($sformatf("FAIL at %0d ns: %s", $time, msg));
    endtask

    task automatic check_data(input fifo_pkg::data_t exp, input fifo_pkg::data_t act);
        if (act !== exp)
            value_mismatch($sformatf("rd_data %h, expected %h", act, exp));
    endtask

    task automatic check_err(input logic exp_single, input logic exp_double,
                             input logic act_single, input logic act_double);
        if ((act_single !== exp_single) || (act_double !== exp_double))
            value_mismatch($sformatf("single_err/double_err %b%b, expected %b%b",
                                     act_single, act_double, exp_single, exp_double));
    endtask

    task automatic check_flags(input flags_t exp, input flags_t act);
        if (act !== exp)
            value_mismatch($sformatf("flags e/f/pe/pf/ovf/udf %b, expected %b, count %0d",
                                     act, exp, model_count));
    endtask

    // one cycle of traffic driven 1 ns after the edge and checked after the next
    task automatic step(input logic wr, input logic rd, input fifo_pkg::inj_mode_e inj);
        logic   w_ok;
        logic   r_ok;
        flags_t exp;
        wr_en    = wr;
        rd_en    = rd;
        wr_data  = fifo_pkg::data_t'(rng);
        inj_mode = inj;
        w_ok     = wr && (model_count != `FIFO_DEPTH);
        r_ok     = rd && (model_count != 0);
        if (r_ok)
        begin
            exp_data.push_back(wq_data.pop_front());
            exp_inj.push_back(wq_inj.pop_front());
            exp_due.push_back(cyc + `FIFO_RD_STAGES);  // accepted next edge
        end
        if (w_ok)
        begin
            wq_data.push_back(wr_data);
            wq_inj.push_back(inj);
        end
        model_count = model_count + (w_ok ? 1 : 0) - (r_ok ? 1 : 0);
        exp         = expected_flags(model_count, model_pf, model_pe, wr && !w_ok, rd && !r_ok);
        model_pf    = exp.prog_full;
        model_pe    = exp.prog_empty;
        @(posedge clk);
        #1;
        check_flags(exp, {empty, full, prog_empty, prog_full, ovf_int, udf_int});
        rng = xorshift(rng);
    endtask

    task automatic write_words(input int n, input fifo_pkg::inj_mode_e inj);
        repeat (n) step(1'b1, 1'b0, inj);
    endtask

    task automatic read_words(input int n);
        repeat (n) step(1'b0, 1'b1, fifo_pkg::INJ_NONE);
    endtask

    task automatic drain_reads();
        while (exp_due.size() != 0)
            step(1'b0, 1'b0, fifo_pkg::INJ_NONE);   // idle until pipeline empties
    endtask

    // ------------------------------------------------------------------------
    // clock, cycle counter, compare
    // ------------------------------------------------------------------------
    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;                  // 4 ns period
    end

    initial
    begin
        cyc = 0;
        forever
        begin
            @(posedge clk);
            cyc++;
            if (cyc >= CYCLE_LIMIT)
                abort_run("timeout: cycle limit reached before the tests finished");
        end
    end

    initial
    begin
        forever
        begin
            @(posedge clk);
            #2;                                 // outputs settled mid cycle
            if (rd_valid)
            begin
                if (exp_due.size() == 0)
                    abort_run("rd_valid went high with no read in flight");
                if (exp_due[0] != cyc)
                    value_mismatch($sformatf("rd_valid at edge %0d, expected edge %0d",
                                             cyc, exp_due[0]));
                check_err(exp_inj[0] == fifo_pkg::INJ_SINGLE,
                          exp_inj[0] == fifo_pkg::INJ_DOUBLE, single_err, double_err);
                if (exp_inj[0] != fifo_pkg::INJ_DOUBLE)
                    check_data(exp_data[0], rd_data);  // double word untrusted
                void'(exp_data.pop_front());
                void'(exp_inj.pop_front());
                void'(exp_due.pop_front());
            end
            else
            begin
                if ((exp_due.size() != 0) && (exp_due[0] <= cyc))
                    abort_run("an accepted read never produced rd_valid");
                check_err(1'b0, 1'b0, single_err, double_err);
            end
        end
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    initial
    begin
        logic fill_phase;
        logic wr;
        logic rd;
        rst_n                = 1'b0;
        wr_en                = 1'b0;
        rd_en                = 1'b0;
        wr_data              = '0;
        inj_mode             = fifo_pkg::INJ_NONE;
        prog_full_assert_cfg = fifo_pkg::count_t'(PF_ASSERT);
        prog_full_negate_cfg = fifo_pkg::count_t'(PF_NEGATE);
        rng                  = 32'd99307;
        model_count          = 0;
        model_pf             = 1'b0;
        model_pe             = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_flags(expected_flags(0, 1'b0, 1'b1, 1'b0, 1'b0),
                    {empty, full, prog_empty, prog_full, ovf_int, udf_int});

        write_words(10, fifo_pkg::INJ_NONE);    // order and latency
        read_words(10);
        drain_reads();

        write_words(18, fifo_pkg::INJ_NONE);    // two writes past full
        read_words(17);                         // one read past empty
        drain_reads();

        for (int i = 0; i < 1200; i++)          // mixed traffic with alternating bias
        begin
            rng        = xorshift(rng);
            fill_phase = ((i / 60) % 2) == 0;
            wr         = fill_phase ? (rng[1:0] != 2'd0) : (rng[1:0] == 2'd0);
            rd         = fill_phase ? (rng[9:8] == 2'd0) : (rng[9:8] != 2'd0);
            step(wr, rd, fifo_pkg::INJ_NONE);
        end
        read_words(model_count);
        drain_reads();

        write_words(8, fifo_pkg::INJ_NONE);     // prog_empty clears at 7
        read_words(6);                          // sets again at 4
        write_words(3, fifo_pkg::INJ_NONE);     // 5 stays inside the band
        write_words(2, fifo_pkg::INJ_NONE);
        read_words(7);
        drain_reads();

        write_words(6, fifo_pkg::INJ_SINGLE);   // corrected flips
        read_words(6);
        drain_reads();

        write_words(4, fifo_pkg::INJ_DOUBLE);   // detected but not corrected
        write_words(2, fifo_pkg::INJ_NONE);
        read_words(6);
        drain_reads();

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+logic
logic/fifo_pkg.sv
logic/fifo_ram_if.sv
logic/fifo_ctrl.sv
logic/ecc_ram.sv
logic/sync_fifo_top.sv
dv/tb_sync_fifo.sv

//--- Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -Wno-fatal
TOP       := tb_sync_fifo
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "test passed" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
